/* Bender.yml */
package:
  name: fma_array

sources:
  - files:
      - source/fma_pkg.sv
      - source/fma_regs.sv
      - source/fma16.sv
      - source/fma_collect.sv
      - source/fma_array.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/fma_array_chk.sv
      - tests/tb_fma_array.sv

/* source/fma16.sv */
// fma16 lane: half-precision fused multiply-add x*y+z
// two pipeline stages, response two cycles after issue
`timescale 1ns/1ps
`default_nettype none

module fma16
    import fma_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  fma_req_t req,
    input  logic     issue,
    output fma_rsp_t rsp,
    output logic     rsp_valid
);

    // stage one signals
    half_t                 y_op;
    half_t                 z_op;
    logic                  xs;
    logic                  ys;
    logic                  zs;
    logic [4:0]            xe;
    logic [4:0]            ye;
    logic [4:0]            ze;
    logic [9:0]            xf;
    logic [9:0]            yf;
    logic [9:0]            zf;
    logic                  ps;
    logic                  zs_eff;
    logic                  sub;
    logic                  x_zero, y_zero, z_zero;
    logic                  x_inf, y_inf, z_inf;
    logic                  nan_any;
    logic                  prod_inf;
    logic                  mul_inv;
    logic                  add_inv;
    logic [10:0]           mx, my, mz;
    logic [21:0]           prod;
    logic [6:0]            p_shift;
    logic [6:0]            z_shift;
    logic [acc_width-1:0]  pa;
    logic [acc_width-1:0]  za;
    logic [acc_width-1:0]  sum;
    logic                  sign;

    // stage one registers
    logic [acc_width-1:0]  s1_sum;
    logic                  s1_sign;
    logic                  s1_special;
    half_t                 s1_spec_val;
    logic                  s1_invalid;
    logic [1:0]            s1_rm;
    logic                  s1_valid;

    // stage two signals
    logic [6:0]            lead;
    logic [6:0]            lzc;
    logic [acc_width-1:0]  norm;
    logic [10:0]           keep;
    logic                  guard;
    logic                  sticky;
    logic                  inexact;
    logic                  round_up;
    logic [11:0]           mant_r;
    logic signed [8:0]     exp_r;
    logic                  ovf_max;
    half_t                 res;
    fma_flags_t            flags;

    // mul=0 multiplies by one, add=0 adds zero
    assign y_op = req.ctrl.mul ? req.y : one_val;
    assign z_op = req.ctrl.add ? req.z : '0;

    assign {xs, xe, xf} = req.x;
    assign {ys, ye, yf} = y_op;
    assign {zs, ze, zf} = z_op;

    assign ps     = xs ^ ys ^ req.ctrl.negp;
    assign zs_eff = zs ^ req.ctrl.negz;
    assign sub    = ps ^ zs_eff;

    // subnormal inputs count as zero
    assign x_zero  = (xe == '0);
    assign y_zero  = (ye == '0);
    assign z_zero  = (ze == '0);
    assign x_inf   = (xe == inf_exp) && (xf == '0);
    assign y_inf   = (ye == inf_exp) && (yf == '0);
    assign z_inf   = (ze == inf_exp) && (zf == '0);
    assign nan_any = ((xe == inf_exp) && (xf != '0)) || ((ye == inf_exp) && (yf != '0))
                  || ((ze == inf_exp) && (zf != '0));

    // inf*0 and inf-inf
    assign mul_inv  = (x_inf && y_zero) || (x_zero && y_inf);
    assign prod_inf = (x_inf || y_inf) && !x_zero && !y_zero && !nan_any;
    assign add_inv  = prod_inf && z_inf && sub;

    assign mx   = x_zero ? 11'd0 : {1'b1, xf};
    assign my   = y_zero ? 11'd0 : {1'b1, yf};
    assign mz   = z_zero ? 11'd0 : {1'b1, zf};
    // exact product, no bits lost
    assign prod = mx * my;

    // both terms placed on the common grid by their exponents
    assign p_shift = 7'(xe + ye - 2 * (exp_bias + man_width) + acc_lsb);
    assign z_shift = 7'(ze - exp_bias - man_width + acc_lsb);
    assign pa      = {{(acc_width - 22){1'b0}}, prod} << p_shift;
    assign za      = {{(acc_width - 11){1'b0}}, mz} << z_shift;

    // signed magnitude add, larger term sets the sign
    always_comb begin
        if (!sub) begin
            sum  = pa + za;
            sign = ps;
        end else if (pa >= za) begin
            sum  = pa - za;
            sign = ps;
        end else begin
            sum  = za - pa;
            sign = zs_eff;
        end
        // exact zero from opposite signs is +0, -0 when rounding down
        if (sum == '0)
            sign = sub ? (req.ctrl.roundmode == rm_down) : ps;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid    <= 1'b0;
            s1_sum      <= '0;
            s1_sign     <= 1'b0;
            s1_special  <= 1'b0;
            s1_spec_val <= '0;
            s1_invalid  <= 1'b0;
            s1_rm       <= '0;
        end else begin
            s1_valid <= issue;
            if (issue) begin
                s1_sum     <= sum;
                s1_sign    <= sign;
                s1_special <= nan_any || mul_inv || add_inv || prod_inf || z_inf;
                s1_invalid <= mul_inv || add_inv;
                s1_rm      <= req.ctrl.roundmode;
                // nan wins over infinity
                if (nan_any || mul_inv || add_inv)
                    s1_spec_val <= qnan_val;
                else if (prod_inf)
                    s1_spec_val <= {ps, inf_exp, 10'b0};
                else
                    s1_spec_val <= {zs_eff, inf_exp, 10'b0};
            end
        end
    end

    // leading one position
    always_comb begin
        lead = '0;
        for (int i = 0; i < acc_width; i++) begin
            if (s1_sum[i])
                lead = 7'(i);
        end
    end

    assign lzc     = 7'(acc_width - 1) - lead;
    assign norm    = s1_sum << lzc;
    assign keep    = norm[acc_width-1 -: 11];
    assign guard   = norm[acc_width-12];
    assign sticky  = |norm[acc_width-13:0];
    assign inexact = guard | sticky;

    always_comb begin
        case (s1_rm)
            rm_rne:  round_up = guard & (sticky | keep[0]);
            rm_down: round_up = s1_sign & inexact;
            rm_up:   round_up = ~s1_sign & inexact;
            default: round_up = 1'b0;
        endcase
    end

    // mantissa carry out bumps the exponent, fraction then wraps to zero
    assign mant_r = {1'b0, keep} + 12'(round_up);
    assign exp_r  = 9'($signed({2'b00, lead}) - (acc_lsb - exp_bias) + int'(mant_r[11]));

    // overflow saturates to max finite when rounding away from infinity
    always_comb begin
        case (s1_rm)
            rm_rz:   ovf_max = 1'b1;
            rm_down: ovf_max = ~s1_sign;
            rm_up:   ovf_max = s1_sign;
            default: ovf_max = 1'b0;
        endcase
    end

    always_comb begin
        if (s1_special) begin
            res   = s1_spec_val;
            flags = {s1_invalid, 3'b000};
        end else if (s1_sum == '0) begin
            res   = {s1_sign, 15'b0};
            flags = '0;
        end else if (exp_r >= 9'sd31) begin
            // 7bff is the largest finite magnitude
            res   = ovf_max ? {s1_sign, 15'h7bff} : {s1_sign, inf_exp, 10'b0};
            flags = 4'b0101;
        end else if (exp_r < 9'sd1) begin
            // tiny after rounding, flushed to signed zero
            res   = {s1_sign, 15'b0};
            flags = 4'b0011;
        end else begin
            res   = {s1_sign, exp_r[4:0], mant_r[9:0]};
            flags = {3'b000, inexact};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= s1_valid;
            if (s1_valid)
                rsp <= '{result: res, flags: flags};
        end
    end

endmodule

`default_nettype wire

/* source/fma_array.sv */
// fma accelerator top
// AXI4-Lite register block, four fma16 lanes and the result collector
`timescale 1ns/1ps
`default_nettype none

module fma_array
    import fma_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [addr_width-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  word_t                 wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [addr_width-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output word_t                 rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    fma_req_t           req [n_lanes];
    fma_rsp_t           rsp [n_lanes];
    fma_rsp_t           results [n_lanes];
    logic [n_lanes-1:0] rsp_valid;
    logic               issue;
    logic               busy;
    logic               done;

    fma_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .req     (req),
        .issue   (issue),
        .results (results),
        .busy    (busy),
        .done    (done)
    );

    // all lanes start on the same issue pulse
    for (genvar i = 0; i < n_lanes; i++) begin : g_lane
        fma16 u_fma16 (
            .clk       (clk),
            .reset     (reset),
            .req       (req[i]),
            .issue     (issue),
            .rsp       (rsp[i]),
            .rsp_valid (rsp_valid[i])
        );
    end

    fma_collect u_collect (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .results   (results),
        .busy      (busy),
        .done      (done)
    );

endmodule

`default_nettype wire

/* source/fma_collect.sv */
// fma result collector
// captures lane responses and tracks busy and done
`timescale 1ns/1ps
`default_nettype none

module fma_collect
    import fma_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  fma_rsp_t           rsp [n_lanes],
    input  logic [n_lanes-1:0] rsp_valid,
    output fma_rsp_t           results [n_lanes],
    output logic               busy,
    output logic               done
);

    logic [n_lanes-1:0] pending;
    logic [n_lanes-1:0] still_pending;

    // lanes reporting this cycle drop out
    assign still_pending = pending & ~rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
            for (int i = 0; i < n_lanes; i++)
                results[i] <= '0;
        end else begin
            for (int i = 0; i < n_lanes; i++) begin
                if (rsp_valid[i])
                    results[i] <= rsp[i];
            end
            if (issue) begin
                pending <= '1;
                busy    <= 1'b1;
                done    <= 1'b0;
            end else begin
                pending <= still_pending;
                // last lane in, results visible together with done
                if (busy && (still_pending == '0)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/fma_pkg.sv */
// fma accelerator package
// bus widths, register map, half-precision constants and lane structs
`default_nettype none

package fma_pkg;

    typedef logic [15:0] half_t;
    typedef logic [31:0] word_t;
    // {invalid, overflow, underflow, inexact}
    typedef logic [3:0]  fma_flags_t;

    localparam int n_lanes    = 4;
    localparam int addr_width = 8;

    // per-lane register block
    localparam int lane_stride = 16;
    localparam int off_xy      = 'h0;
    localparam int off_zc      = 'h4;
    localparam int off_res     = 'h8;
    // global control, above the lane blocks
    localparam logic [addr_width-1:0] addr_start  = 8'h40;
    localparam logic [addr_width-1:0] addr_status = 8'h44;

    // half-precision layout
    localparam int         exp_bias  = 15;
    localparam int         man_width = 10;
    localparam logic [4:0] inf_exp   = 5'h1f;
    localparam half_t      qnan_val  = 16'h7e00;
    localparam half_t      one_val   = 16'h3c00;

    // rounding mode codes
    localparam logic [1:0] rm_rz   = 2'd0;
    localparam logic [1:0] rm_rne  = 2'd1;
    localparam logic [1:0] rm_down = 2'd2;
    localparam logic [1:0] rm_up   = 2'd3;

    // lane accumulator, bit 0 weighs 2^-acc_lsb
    // smallest product ulp is 2^-48, largest term stays below 2^81
    localparam int acc_width = 82;
    localparam int acc_lsb   = 48;

    typedef struct packed {
        logic [1:0] roundmode;
        logic       mul;
        logic       add;
        logic       negp;
        logic       negz;
    } fma_ctrl_t;

    typedef struct packed {
        half_t     x;
        half_t     y;
        half_t     z;
        fma_ctrl_t ctrl;
    } fma_req_t;

    typedef struct packed {
        half_t      result;
        fma_flags_t flags;
    } fma_rsp_t;

    typedef enum logic {
        idle,
        respond
    } axi_state_t;

endpackage

`default_nettype wire

/* source/fma_regs.sv */
// fma register block: AXI4-Lite slave holding lane operands
// issues a start pulse to the lanes and reads back results and status
`timescale 1ns/1ps
`default_nettype none

module fma_regs
    import fma_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // write address and data
    input  logic [addr_width-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  word_t                 wdata,
    input  logic                  wvalid,
    output logic                  wready,
    // write response
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    // read address and data
    input  logic [addr_width-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output word_t                 rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // lane side
    output fma_req_t              req [n_lanes],
    output logic                  issue,
    input  fma_rsp_t              results [n_lanes],
    input  logic                  busy,
    input  logic                  done
);

    axi_state_t wr_state;
    axi_state_t rd_state;
    logic       wr_accept;
    logic       rd_accept;
    word_t      rd_word;

    // address and data taken together, only when no response is pending
    assign wr_accept = (wr_state == idle) && awvalid && wvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign bvalid    = (wr_state == respond);
    // always OKAY
    assign bresp     = 2'b00;

    assign rd_accept = (rd_state == idle) && arvalid;
    assign arready   = rd_accept;
    assign rvalid    = (rd_state == respond);
    assign rresp     = 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_state <= idle;
            issue    <= 1'b0;
            for (int i = 0; i < n_lanes; i++)
                req[i] <= '0;
        end else begin
            // start ignored while busy or already issuing
            issue <= wr_accept && (awaddr == addr_start) && wdata[0] && !busy && !issue;
            case (wr_state)
                idle:    if (wr_accept) wr_state <= respond;
                respond: if (bready) wr_state <= idle;
                default: wr_state <= idle;
            endcase
            if (wr_accept) begin
                for (int i = 0; i < n_lanes; i++) begin
                    if (int'(awaddr) == i * lane_stride + off_xy) begin
                        req[i].y <= wdata[31:16];
                        req[i].x <= wdata[15:0];
                    end
                    // control word sits right above z
                    if (int'(awaddr) == i * lane_stride + off_zc) begin
                        req[i].ctrl <= wdata[21:16];
                        req[i].z    <= wdata[15:0];
                    end
                end
            end
        end
    end

    // read mux, unmapped and start read as zero
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < n_lanes; i++) begin
            if (int'(araddr) == i * lane_stride + off_xy)
                rd_word = {req[i].y, req[i].x};
            if (int'(araddr) == i * lane_stride + off_zc)
                rd_word = {10'b0, req[i].ctrl, req[i].z};
            if (int'(araddr) == i * lane_stride + off_res)
                rd_word = {12'b0, results[i].flags, results[i].result};
        end
        if (araddr == addr_status)
            rd_word = {30'b0, done, busy};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= idle;
            rdata    <= '0;
        end else begin
            case (rd_state)
                idle:    if (rd_accept) rd_state <= respond;
                respond: if (rready) rd_state <= idle;
                default: rd_state <= idle;
            endcase
            // data held until rready
            if (rd_accept)
                rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* tests/fma_array_chk.sv */
// fma_array protocol checker
// AXI4-Lite response holding, lane latency and reset state
`timescale 1ns/1ps
`default_nettype none

module fma_array_chk
    import fma_pkg::*;
(
    input logic               clk,
    input logic               reset,
    input logic               awready,
    input logic               wready,
    input logic               bvalid,
    input logic               bready,
    input logic               arready,
    input logic               rvalid,
    input logic               rready,
    input word_t              rdata,
    input logic               issue,
    input logic [n_lanes-1:0] rsp_valid
);

    // failures seen, summed into the closing line
    int fail_count = 0;

    // write response waits for bready
    assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
        else begin fail_count++; $error("bvalid dropped before bready"); end

    // read data held with rvalid
    assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin fail_count++; $error("rvalid or rdata changed before rready"); end

    // every lane answers two cycles after issue
    assert property (@(posedge clk) disable iff (reset) issue |=> ##1 (&rsp_valid))
        else begin fail_count++; $error("lane response missing two cycles after issue"); end

    assert property (@(posedge clk) disable iff (reset) (|rsp_valid) |-> $past(issue, 2))
        else begin fail_count++; $error("lane response without issue"); end

    // quiet outputs while in reset
    assert property (@(posedge clk)
        reset |=> !(awready || wready || bvalid || arready || rvalid || issue || (|rsp_valid)))
        else begin fail_count++; $error("handshake output active during reset"); end

endmodule

bind fma_array fma_array_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .awready   (awready),
    .wready    (wready),
    .bvalid    (bvalid),
    .bready    (bready),
    .arready   (arready),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .issue     (issue),
    .rsp_valid (rsp_valid)
);

`default_nettype wire

/* tests/tb_clock.sv */
// testbench clock source
// free-running clock, starts low
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* tests/tb_fma_array.sv */
// fma_array testbench
// random batches over the bus, checked against a wide-integer fma model
`timescale 1ns/1ps
`default_nettype none

module tb_fma_array
    import fma_pkg::*;
;

    localparam int clk_period_ns    = 100;
    localparam int n_batches        = 50;
    localparam int cycles_per_batch = 200;

    logic                  clk;
    logic                  reset;
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    word_t                 wdata;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    word_t                 rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    int                    errors;
    half_t                 lane_x [n_lanes];
    half_t                 lane_y [n_lanes];
    half_t                 lane_z [n_lanes];
    logic [5:0]            lane_ctrl [n_lanes];

    // operands worth hitting: zeros, infinities, nans, subnormals, extremes
    half_t specials [12] = '{16'h0000, 16'h8000, 16'h7c00, 16'hfc00, 16'h7e00, 16'h7d01,
                             16'h0001, 16'h03ff, 16'h7bff, 16'hfbff, 16'h0400, 16'h3c00};

    tb_clock #(.period_ns(clk_period_ns)) u_clock (.clk(clk));

    fma_array uut (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Fail %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    function automatic logic [addr_width-1:0] lane_addr(input int lane, input int off);
        return addr_width'(lane * lane_stride + off);
    endfunction

    // reference fma, exact sum in units of 2^-48, returns {result, flags}
    function automatic logic [19:0] fma_model(input half_t x, input half_t y_in,
                                              input half_t z_in, input logic [5:0] ctrl);
        half_t              y;
        half_t              z;
        logic [1:0]         rm;
        logic               ps, zsn, nan, p_inf, inv, sign, inexact, up, to_max;
        logic               x_zero, y_zero, z_zero, x_inf, y_inf, z_inf;
        logic signed [95:0] pval, zval, sval;
        logic [95:0]        mag, rem, half_ulp;
        logic [11:0]        mant;
        int                 lead, sh, e;
        rm  = ctrl[5:4];
        y   = ctrl[3] ? y_in : 16'h3c00;
        z   = ctrl[2] ? z_in : 16'h0000;
        ps  = x[15] ^ y[15] ^ ctrl[1];
        zsn = z[15] ^ ctrl[0];
        // exponent zero covers subnormals too
        x_zero = (x[14:10] == 5'd0);
        y_zero = (y[14:10] == 5'd0);
        z_zero = (z[14:10] == 5'd0);
        x_inf  = (x[14:0] == 15'h7c00);
        y_inf  = (y[14:0] == 15'h7c00);
        z_inf  = (z[14:0] == 15'h7c00);
        nan    = (x[14:0] > 15'h7c00) || (y[14:0] > 15'h7c00) || (z[14:0] > 15'h7c00);
        p_inf  = (x_inf || y_inf) && !x_zero && !y_zero;
        inv    = (x_inf && y_zero) || (y_inf && x_zero)
              || (!nan && p_inf && z_inf && (ps != zsn));
        if (nan || inv)
            return {16'h7e00, inv, 3'b000};
        if (p_inf)
            return {ps, 15'h7c00, 4'b0000};
        if (z_inf)
            return {zsn, 15'h7c00, 4'b0000};
        pval = '0;
        zval = '0;
        if (!x_zero && !y_zero) begin
            pval = 96'({1'b1, x[9:0]}) * 96'({1'b1, y[9:0]});
            pval = pval << (int'(x[14:10]) + int'(y[14:10]) - 2);
        end
        if (!z_zero)
            zval = 96'({1'b1, z[9:0]}) << (int'(z[14:10]) + 23);
        if (ps)
            pval = -pval;
        if (zsn)
            zval = -zval;
        sval = pval + zval;
        // exact zero, -0 only from like signs or rounding down
        if (sval == 0)
            return {(ps == zsn) ? ps : (rm == 2'd2), 15'h0000, 4'b0000};
        sign = (sval < 0);
        mag  = sign ? -sval : sval;
        lead = 0;
        for (int i = 0; i < 96; i++) begin
            if (mag[i])
                lead = i;
        end
        e = lead - 33;
        if (lead >= 10) begin
            sh       = lead - 10;
            mant     = 12'(mag >> sh);
            rem      = mag & ((96'd1 << sh) - 96'd1);
            half_ulp = (sh > 0) ? (96'd1 << (sh - 1)) : 96'd0;
        end else begin
            mant     = 12'(mag << (10 - lead));
            rem      = '0;
            half_ulp = '0;
        end
        inexact = (rem != 0);
        case (rm)
            2'd1:    up = (rem > half_ulp) || ((rem == half_ulp) && inexact && mant[0]);
            2'd2:    up = sign && inexact;
            2'd3:    up = !sign && inexact;
            default: up = 1'b0;
        endcase
        mant = mant + 12'(up);
        if (mant[11]) begin
            mant = mant >> 1;
            e    = e + 1;
        end
        if (e >= 31) begin
            to_max = (rm == 2'd0) || ((rm == 2'd2) && !sign) || ((rm == 2'd3) && sign);
            return {sign, to_max ? 15'h7bff : 15'h7c00, 4'b0101};
        end
        if (e < 1)
            return {sign, 15'h0000, 4'b0011};
        return {sign, 5'(e), mant[9:0], 3'b000, inexact};
    endfunction

    function automatic half_t random_normal();
        return {1'($urandom), 5'($urandom_range(1, 30)), 10'($urandom)};
    endfunction

    function automatic half_t pick_operand();
        if ($urandom_range(0, 1) == 0)
            return specials[$urandom_range(0, 11)];
        return random_normal();
    endfunction

    // dly holds bready low that many cycles after bvalid
    task automatic bus_write(input logic [addr_width-1:0] addr, input word_t data,
                             input int dly);
        int waits;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (dly == 0);
        waits   = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!bvalid && waits < 16);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) begin
            $display("write to address %h got no response", addr);
            errors++;
        end else begin
            // every write answers OKAY
            check_value("bresp", bresp, 32'h0);
            for (int i = 0; i < dly; i++) begin
                @(negedge clk);
                check_value("bvalid", bvalid, 32'h1);
            end
            bready = 1'b1;
        end
    endtask

    task automatic bus_read(input logic [addr_width-1:0] addr, output word_t data,
                            input int dly);
        int waits;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (dly == 0);
        waits   = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!rvalid && waits < 16);
        arvalid = 1'b0;
        data    = rdata;
        if (!rvalid) begin
            $display("read from address %h got no response", addr);
            errors++;
        end else begin
            check_value("rresp", rresp, 32'h0);
            // data must survive the stalled rready
            for (int i = 0; i < dly; i++) begin
                @(negedge clk);
                check_value("rvalid", rvalid, 32'h1);
                check_value("rdata", rdata, data);
            end
            rready = 1'b1;
        end
    endtask

    task automatic choose_operands(input int b, input int i);
        logic [1:0] rm;
        logic       mul, add, negp, negz;
        rm        = 2'($urandom);
        negp      = 1'($urandom);
        negz      = 1'($urandom);
        mul       = 1'b1;
        add       = 1'b1;
        lane_x[i] = random_normal();
        lane_y[i] = random_normal();
        lane_z[i] = random_normal();
        if (b < 5) begin
            // multiply only, every rounding mode across the lanes
            add = 1'b0;
            rm  = 2'(b + i);
        end else if (b < 10) begin
            mul = 1'b0;
            rm  = 2'(b + i);
        end else if (b >= 40) begin
            lane_x[i] = pick_operand();
            lane_y[i] = pick_operand();
            lane_z[i] = pick_operand();
            mul       = ($urandom_range(0, 7) != 0);
            add       = ($urandom_range(0, 7) != 0);
        end else if ($urandom_range(0, 3) == 0) begin
            // x*1 - x cancels exactly
            lane_y[i] = 16'h3c00;
            lane_z[i] = lane_x[i];
            negz      = ~negp;
        end
        lane_ctrl[i] = {rm, mul, add, negp, negz};
    endtask

    task automatic start_and_wait(input logic twice);
        word_t st;
        int    polls;
        bus_write(addr_start, 32'h1, 0);
        if (twice) begin
            // second start arrives while the lanes still run
            bus_write(addr_start, 32'h1, 0);
            bus_read(addr_status, st, 0);
            check_value("status after ignored start", st, 32'h2);
        end else begin
            bus_read(addr_status, st, 0);
            check_value("status after start", st, 32'h1);
            polls = 0;
            while (st != 32'h2 && polls < 16) begin
                bus_read(addr_status, st, 0);
                if (st != 32'h1 && st != 32'h2) begin
                    $display("status showed neither busy nor done: %h", st);
                    errors++;
                end
                polls++;
            end
            if (st != 32'h2) begin
                $display("status never reached done after start");
                errors++;
            end
        end
    endtask

    task automatic run_batch(input int b);
        word_t       rd;
        logic [19:0] want;
        int          dly;
        // every fifth batch stalls the response channels
        dly = (b % 5 == 4) ? $urandom_range(1, 3) : 0;
        for (int i = 0; i < n_lanes; i++) begin
            choose_operands(b, i);
            bus_write(lane_addr(i, off_xy), {lane_y[i], lane_x[i]}, dly);
            bus_write(lane_addr(i, off_zc), {10'b0, lane_ctrl[i], lane_z[i]}, dly);
        end
        for (int i = 0; i < n_lanes; i++) begin
            bus_read(lane_addr(i, off_xy), rd, dly);
            check_value($sformatf("lane%0d xy", i), rd, {lane_y[i], lane_x[i]});
            bus_read(lane_addr(i, off_zc), rd, dly);
            check_value($sformatf("lane%0d zc", i), rd, {10'b0, lane_ctrl[i], lane_z[i]});
        end
        start_and_wait(b % 10 == 3);
        for (int i = 0; i < n_lanes; i++) begin
            bus_read(lane_addr(i, off_res), rd, dly);
            want = fma_model(lane_x[i], lane_y[i], lane_z[i], lane_ctrl[i]);
            check_value($sformatf("lane%0d result", i), rd[15:0], want[19:4]);
            check_value($sformatf("lane%0d flags", i), rd[31:16], want[3:0]);
        end
    endtask

    initial begin
        errors  = 0;
        void'($urandom(52695));
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int b = 0; b < n_batches; b++)
            run_batch(b);
        $display("%0d check errors, %0d assertion failures", errors, uut.u_chk.fail_count);
        if (errors == 0 && uut.u_chk.fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // watchdog sized from the batch count
    initial begin
        #(n_batches * cycles_per_batch * clk_period_ns);
        $display("watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/fma_pkg.sv
source/fma_regs.sv
source/fma16.sv
source/fma_collect.sv
source/fma_array.sv
tests/tb_clock.sv
tests/fma_array_chk.sv
tests/tb_fma_array.sv
